/* compile.f */
hw/datapathPkg.sv
hw/regSelectDecode.sv
hw/busRegister.sv
hw/busMux.sv
hw/aluUnit.sv
hw/memoryInterface.sv
hw/singleBusDatapath.sv
verif/datapathTb.sv

/* hw/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
    input  logic Clock,
    input  logic rstN,
    input  datapathPkg::word_t busData,
    input  datapathPkg::word_t yValue,
    input  datapathPkg::aluOp_t opcode,
    input  logic zIn,
    input  logic incPc,
    input  logic zOut,
    output datapathPkg::word_t zDrive
);
    import datapathPkg::*;

    word_t aluResult;
    word_t zReg;
    logic [shiftAmountWidth-1:0] shiftAmount;

    assign shiftAmount = busData[shiftAmountWidth-1:0];

    // Y is always the left operand, bus the right
    always_comb begin
        case (opcode)
            aluAdd: begin
                aluResult = yValue + busData;
            end
            aluSub: begin
                aluResult = yValue - busData;
            end
            aluAnd: begin
                aluResult = yValue & busData;
            end
            aluOr: begin
                aluResult = yValue | busData;
            end
            aluShr: begin
                aluResult = yValue >> shiftAmount;   // logical shift
            end
            aluShl: begin
                aluResult = yValue << shiftAmount;
            end
            aluNeg: begin
                aluResult = -busData;   // unary ops ignore Y
            end
            aluNot: begin
                aluResult = ~busData;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zIn) begin
            // PC increment path bypasses the opcode
            if (incPc) begin
                zReg <= busData + word_t'(1);
            end else begin
                zReg <= aluResult;
            end
        end
    end

    assign zDrive = zOut ? zReg : '0;

endmodule

/* hw/busMux.sv */
`timescale 1ns/100ps

module busMux (
    input  datapathPkg::word_t gpDrive [datapathPkg::regCount],
    input  datapathPkg::word_t pcDrive,
    input  datapathPkg::word_t irDrive,
    input  datapathPkg::word_t zDrive,
    input  datapathPkg::word_t mdrDrive,
    input  logic [datapathPkg::regCount-1:0] regRead,
    input  logic pcOut,
    input  logic zOut,
    input  logic mdrOut,
    output datapathPkg::word_t busData,
    output logic busConflict
);
    import datapathPkg::*;

    localparam int selectCount = regCount + 3;
    localparam int countWidth = $clog2(selectCount + 1);

    logic [selectCount-1:0] outSelects;
    logic [countWidth-1:0] activeCount;
    word_t gpOr;

    // general registers first, each already gated by its own select
    always_comb begin
        gpOr = '0;
        for (int i = 0; i < regCount; i++) begin
            gpOr = gpOr | gpDrive[i];
        end
    end

    assign busData = gpOr | pcDrive | irDrive | zDrive | mdrDrive;

    assign outSelects = {regRead, pcOut, zOut, mdrOut};

    // more than one driver at once means two sources are fighting
    always_comb begin
        activeCount = '0;
        for (int i = 0; i < selectCount; i++) begin
            activeCount = activeCount + countWidth'(outSelects[i]);
        end
    end

    assign busConflict = activeCount > countWidth'(1);

endmodule

/* hw/busRegister.sv */
`timescale 1ns/100ps

module busRegister #(
    parameter type payload_t = datapathPkg::word_t
) (
    input  logic Clock,
    input  logic rstN,
    input  datapathPkg::word_t busData,
    input  logic load,
    input  logic drive,
    output payload_t value,
    output datapathPkg::word_t busDrive
);
    import datapathPkg::*;

    localparam int payloadWidth = $bits(payload_t);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            value <= '0;
        end else if (load) begin
            value <= payload_t'(busData[payloadWidth-1:0]);   // narrow payloads keep low bits
        end
    end

    // zero when not selected so drivers can be ORed together
    assign busDrive = drive ? word_t'(value) : '0;

endmodule

/* hw/datapathPkg.sv */
package datapathPkg;

    // bus and register file sizing
    localparam int wordWidth = 32;
    localparam int regCount = 16;
    localparam int regIdxWidth = 4;
    localparam int addrWidth = 9;   // MAR and PC only reach this far

    localparam int shiftAmountWidth = 5;    // low bits of bus word give the shift count

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [addrWidth-1:0] addr_t;

    // ALU operation codes, as carried in the IR opcode field
    typedef enum logic [4:0] {
        aluAdd = 5'b00011,
        aluSub = 5'b00100,
        aluAnd = 5'b00101,
        aluOr  = 5'b00110,
        aluShr = 5'b00111,
        aluShl = 5'b01000,
        aluNeg = 5'b01111,
        aluNot = 5'b10000
    } aluOp_t;

    // IR field positions
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;

endpackage

/* hw/memoryInterface.sv */
`timescale 1ns/100ps

module memoryInterface (
    input  logic Clock,
    input  logic rstN,
    input  datapathPkg::word_t busData,
    input  datapathPkg::word_t mDataIn,
    input  logic marIn,
    input  logic mdrIn,
    input  logic read,
    input  logic mdrOut,
    output datapathPkg::addr_t memAddr,
    output datapathPkg::word_t mdrDrive
);
    import datapathPkg::*;

    addr_t marReg;
    word_t mdrReg;
    word_t mdrSource;

    // address only needs the low bits of the bus
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            marReg <= '0;
        end else if (marIn) begin
            marReg <= busData[addrWidth-1:0];
        end
    end

    assign mdrSource = read ? mDataIn : busData;   // memory on read, else bus write-back

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrReg <= '0;
        end else if (mdrIn) begin
            mdrReg <= mdrSource;
        end
    end

    assign memAddr = marReg;
    assign mdrDrive = mdrOut ? mdrReg : '0;

endmodule

/* hw/regSelectDecode.sv */
`timescale 1ns/100ps

module regSelectDecode (
    input  datapathPkg::word_t ir,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic rIn,
    input  logic rOut,
    output logic [datapathPkg::regCount-1:0] regWrite,
    output logic [datapathPkg::regCount-1:0] regRead
);
    import datapathPkg::*;

    logic [regIdxWidth-1:0] regIdx;
    logic fieldValid;
    logic [regCount-1:0] regOneHot;

    assign fieldValid = gra | grb | grc;

    // ra takes priority, then rb, then rc
    always_comb begin
        if (gra) begin
            regIdx = ir[raMsb:raLsb];
        end else if (grb) begin
            regIdx = ir[rbMsb:rbLsb];
        end else begin
            regIdx = ir[rcMsb:rcLsb];
        end
    end

    always_comb begin
        regOneHot = '0;
        if (fieldValid) begin
            regOneHot[regIdx] = 1'b1;
        end
    end

    assign regWrite = rIn ? regOneHot : '0;    // load strobe per register
    assign regRead = rOut ? regOneHot : '0;    // out-select per register

endmodule

/* hw/singleBusDatapath.sv */
`timescale 1ns/100ps

module singleBusDatapath (
    input  logic Clock,
    input  logic rstN,
    input  logic pcOut,
    input  logic zOut,
    input  logic mdrOut,
    input  logic rOut,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic rIn,
    input  logic marIn,
    input  logic mdrIn,
    input  logic read,
    input  logic pcIn,
    input  logic irIn,
    input  logic yIn,
    input  logic zIn,
    input  logic incPc,
    input  datapathPkg::aluOp_t opcode,
    input  datapathPkg::word_t mDataIn,
    output datapathPkg::word_t busData,
    output datapathPkg::addr_t memAddr,
    output logic busConflict
);
    import datapathPkg::*;

    logic [regCount-1:0] regWrite;
    logic [regCount-1:0] regRead;
    word_t gpDrive [regCount];
    word_t irValue;
    word_t yValue;
    word_t pcDrive;
    word_t zDrive;
    word_t mdrDrive;

    regSelectDecode regSelectDecode_i (
        .ir(irValue),
        .gra(gra),
        .grb(grb),
        .grc(grc),
        .rIn(rIn),
        .rOut(rOut),
        .regWrite(regWrite),
        .regRead(regRead)
    );

    // general register file, R0 to R15
    for (genvar i = 0; i < regCount; i++) begin : gpReg
        busRegister #(.payload_t(word_t)) gpReg_i (
            .Clock(Clock),
            .rstN(rstN),
            .busData(busData),
            .load(regWrite[i]),
            .drive(regRead[i]),
            .value(),
            .busDrive(gpDrive[i])
        );
    end

    busRegister #(.payload_t(addr_t)) pcReg_i (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .load(pcIn),
        .drive(pcOut),
        .value(),
        .busDrive(pcDrive)
    );

    // IR never drives the bus, only feeds the decoder
    busRegister #(.payload_t(word_t)) irReg_i (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .load(irIn),
        .drive(1'b0),
        .value(irValue),
        .busDrive()
    );

    busRegister #(.payload_t(word_t)) yReg_i (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .load(yIn),
        .drive(1'b0),
        .value(yValue),
        .busDrive()
    );

    busMux busMux_i (
        .gpDrive(gpDrive),
        .pcDrive(pcDrive),
        .irDrive('0),
        .zDrive(zDrive),
        .mdrDrive(mdrDrive),
        .regRead(regRead),
        .pcOut(pcOut),
        .zOut(zOut),
        .mdrOut(mdrOut),
        .busData(busData),
        .busConflict(busConflict)
    );

    aluUnit aluUnit_i (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .yValue(yValue),
        .opcode(opcode),
        .zIn(zIn),
        .incPc(incPc),
        .zOut(zOut),
        .zDrive(zDrive)
    );

    memoryInterface memoryInterface_i (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .mDataIn(mDataIn),
        .marIn(marIn),
        .mdrIn(mdrIn),
        .read(read),
        .mdrOut(mdrOut),
        .memAddr(memAddr),
        .mdrDrive(mdrDrive)
    );

endmodule

/* run.sh */
#!/bin/sh
# builds the datapath testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module datapathTb \
    --Mdir build/obj \
    -o datapathSim

# a $fatal in the testbench gives a nonzero exit status here
./build/obj/datapathSim

/* verif/datapathTb.sv */
`timescale 1ns/100ps

module datapathTb;
    import datapathPkg::*;

    localparam int stepTimeout = 4;     // cycles allowed for one control step
    localparam int addrTimeout = 8;

    logic Clock = 1'b0;
    logic rstN;
    logic pcOut, zOut, mdrOut, rOut, gra, grb, grc, rIn;
    logic marIn, mdrIn, read, pcIn, irIn, yIn, zIn, incPc;
    aluOp_t opcode;
    word_t mDataIn;
    word_t busData;
    addr_t memAddr;
    logic busConflict;

    // reference model state
    word_t regModel [regCount];
    word_t irModel, yModel, zModel, mdrModel;
    addr_t pcModel, marModel;
    word_t expBus;
    logic expConflict;
    int edgeCount = 0;

    aluOp_t opList [8] = '{aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShl, aluNeg, aluNot};

    singleBusDatapath singleBusDatapath_i (.*);

    always #20 Clock = ~Clock;

    always @(posedge Clock) begin
        edgeCount <= edgeCount + 1;
    end

    task automatic failRun(string reason);
        $display("=== FAIL ===");
        $fatal(1, reason);
    endtask

    task automatic reportMismatch(string what, word_t got, word_t expected);
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
        failRun("wrong value seen on the datapath");
    endtask

    busValueCheck: assert property (@(posedge Clock) disable iff (!rstN) busData == expBus)
        else reportMismatch("busData", $sampled(busData), expBus);
    conflictCheck: assert property (@(posedge Clock) disable iff (!rstN)
            busConflict == expConflict)
        else reportMismatch("busConflict", word_t'($sampled(busConflict)), word_t'(expConflict));
    addressCheck: assert property (@(posedge Clock) disable iff (!rstN) memAddr == marModel)
        else reportMismatch("memAddr", word_t'($sampled(memAddr)), word_t'(marModel));

    function automatic word_t aluModel(aluOp_t op, word_t left, word_t right);
        case (op)
            aluAdd: return left + right;
            aluSub: return left + ~right + 32'd1;     // two's complement subtract
            aluAnd: return left & right;
            aluOr:  return left | right;
            aluShr: return left >> right[4:0];
            aluShl: return left << right[4:0];
            aluNeg: return ~right + 32'd1;
            aluNot: return ~right;
            default: return '0;
        endcase
    endfunction

    function automatic logic anyField();
        return gra | grb | grc;
    endfunction

    // ra before rb before rc
    function automatic logic [regIdxWidth-1:0] selectedField();
        if (gra) begin
            return irModel[raMsb:raLsb];
        end else if (grb) begin
            return irModel[rbMsb:rbLsb];
        end
        return irModel[rcMsb:rcLsb];
    endfunction

    task automatic clearStrobes();
        {pcOut, zOut, mdrOut, rOut, gra, grb, grc, rIn} = '0;
        {marIn, mdrIn, read, pcIn, irIn, yIn, zIn, incPc} = '0;
    endtask

    task automatic predictBus();
        int drivers;
        word_t value;
        drivers = 0;
        value = '0;
        if (rOut && anyField()) begin
            value = value | regModel[selectedField()];
            drivers++;
        end
        if (pcOut) begin
            value = value | word_t'(pcModel);
            drivers++;
        end
        if (zOut) begin
            value = value | zModel;
            drivers++;
        end
        if (mdrOut) begin
            value = value | mdrModel;
            drivers++;
        end
        expBus = value;
        expConflict = drivers > 1;
    endtask

    task automatic updateModel();
        word_t zNext;
        zNext = incPc ? expBus + 32'd1 : aluModel(opcode, yModel, expBus);
        if (zIn) zModel = zNext;
        if (rIn && anyField()) regModel[selectedField()] = expBus;  // uses IR before irIn
        if (pcIn) pcModel = expBus[addrWidth-1:0];
        if (irIn) irModel = expBus;
        if (yIn) yModel = expBus;
        if (marIn) marModel = expBus[addrWidth-1:0];
        if (mdrIn) mdrModel = read ? mDataIn : expBus;
    endtask

    // one control step, strobes already driven at this falling edge
    task automatic runStep();
        int polls;
        int startEdges;
        predictBus();
        startEdges = edgeCount;
        polls = 0;
        do begin
            @(negedge Clock);
            polls++;
        end while (edgeCount == startEdges && polls < stepTimeout);
        if (edgeCount == startEdges) begin
            $display("Timeout: no rising clock edge arrived for a control step");
            failRun("control step timed out");
        end
        if (rstN) updateModel();
        clearStrobes();
        predictBus();   // idle cycles expect an empty bus
    endtask

    task automatic waitForAddress(addr_t expected);
        int polls;
        polls = 0;
        while (memAddr !== expected && polls < addrTimeout) begin
            @(negedge Clock);
            polls++;
        end
        if (memAddr !== expected) begin
            $display("Timeout: memAddr never showed the address loaded into MAR");
            failRun("memory address timed out");
        end
    endtask

    task automatic selectField(int field);
        gra = field == 0;
        grb = field == 1;
        grc = field == 2;
    endtask

    task automatic loadMdr(word_t data);
        mDataIn = data;
        read = 1'b1;
        mdrIn = 1'b1;
        runStep();
    endtask

    task automatic loadIr(word_t instr);
        loadMdr(instr);
        mdrOut = 1'b1;
        irIn = 1'b1;
        runStep();
    endtask

    task automatic writeReg(int field, word_t data);
        loadMdr(data);
        mdrOut = 1'b1;
        selectField(field);
        rIn = 1'b1;
        runStep();
    endtask

    task automatic driveReg(int field);
        rOut = 1'b1;
        selectField(field);
        runStep();
    endtask

    initial begin
        addr_t pcStart;
        void'($urandom(32'hb753_79c0));
        for (int i = 0; i < regCount; i++) regModel[i] = '0;
        {irModel, yModel, zModel, mdrModel} = '0;
        pcModel = '0;
        marModel = '0;
        clearStrobes();
        opcode = aluAdd;
        mDataIn = '0;
        rstN = 1'b0;
        repeat (3) runStep();
        rstN = 1'b1;
        runStep();      // empty bus, no conflict, address zero

        // registers picked through random IR fields
        for (int round = 0; round < 4; round++) begin
            loadIr($urandom);
            for (int f = 0; f < 3; f++) writeReg(f, $urandom);
            for (int f = 0; f < 3; f++) driveReg(f);
        end

        foreach (opList[k]) begin
            loadMdr($urandom);
            mdrOut = 1'b1;
            yIn = 1'b1;
            runStep();
            loadMdr($urandom);
            mdrOut = 1'b1;
            opcode = opList[k];
            zIn = 1'b1;
            runStep();
            zOut = 1'b1;
            runStep();
        end

        // or R1, R2, R3 with operands preloaded
        loadIr(32'h30918000);
        writeReg(1, $urandom);
        writeReg(2, $urandom);
        loadMdr($urandom);
        mdrOut = 1'b1;
        pcIn = 1'b1;
        runStep();
        pcStart = pcModel;
        opcode = aluAdd;
        pcOut = 1'b1;   // fetch: PC to MAR, PC plus one into Z
        marIn = 1'b1;
        incPc = 1'b1;
        zIn = 1'b1;
        runStep();
        waitForAddress(pcStart);
        zOut = 1'b1;
        pcIn = 1'b1;
        read = 1'b1;
        mdrIn = 1'b1;
        mDataIn = 32'h30918000;
        runStep();
        mdrOut = 1'b1;
        irIn = 1'b1;
        runStep();
        rOut = 1'b1;
        selectField(1);
        yIn = 1'b1;
        runStep();
        rOut = 1'b1;
        selectField(2);
        opcode = aluOr;
        zIn = 1'b1;
        runStep();
        zOut = 1'b1;
        selectField(0);
        rIn = 1'b1;
        runStep();
        pcOut = 1'b1;
        runStep();
        driveReg(0);

        // two and three drivers at once, then idle
        pcOut = 1'b1;
        rOut = 1'b1;
        selectField(0);
        runStep();
        runStep();
        zOut = 1'b1;
        mdrOut = 1'b1;
        rOut = 1'b1;
        selectField(2);
        runStep();
        runStep();

        $display("=== PASS ===");
        $finish;
    end

endmodule
